// File: rtl/uart_hello_defines.svh
// Fixed build constants: 87 clocks per bit gives 115200 baud only from a 10 MHz clock
`ifndef UART_HELLO_DEFINES_SVH
`define UART_HELLO_DEFINES_SVH

// Clock cycles per serial bit, 10 MHz / 115200 rounded
`define CLKS_PER_BIT 87

// FIFO entries, must stay a power of two
`define FIFO_DEPTH 16

// Bytes in the repeated message, CR and LF included
`define MSG_LEN 15

`endif

// File: rtl/uart_hello_pkg.sv
// Shared types; msg_idx_t is sized from MSG_LEN, so changing the message length resizes the index
`default_nettype none

`include "uart_hello_defines.svh"

package uart_hello_pkg;

  // One data byte on every link
  typedef logic [7:0] byte_t;

  // Message table index, wide enough for MSG_LEN entries
  typedef logic [$clog2(`MSG_LEN)-1:0] msg_idx_t;

  // Transmitter FSM states, 8N1 frame order
  typedef enum logic [1:0] {
    IDLE,
    START,
    DATA,
    STOP
  } tx_state_e;

endpackage

`default_nettype wire

// File: rtl/message_source.sv
// Writes at most one byte every other cycle so that full_i always includes the last write
`timescale 1ns/1ps
`default_nettype none

`include "uart_hello_defines.svh"

module message_source (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  enable_i,
  output uart_hello_pkg::byte_t wr_data_o,
  output logic                  wr_en_o,
  input  logic                  full_i
);

  import uart_hello_pkg::*;

  // Message text, ready from reset
  localparam byte_t MSG_TABLE [0:`MSG_LEN-1] = '{
    8'h48,  // H
    8'h65,  // e
    8'h6C,  // l
    8'h6C,  // l
    8'h6F,  // o
    8'h2C,  // ,
    8'h20,  // space
    8'h46,  // F
    8'h69,  // i
    8'h66,  // f
    8'h6F,  // o
    8'h21,  // !
    8'h21,  // !
    8'h0D,  // CR
    8'h0A   // LF
  };

  localparam msg_idx_t LAST_IDX = msg_idx_t'(`MSG_LEN - 1);

  msg_idx_t idx_q;
  logic     push;

  // A pending write is not yet seen by full_i, so wait it out
  assign push = enable_i && !full_i && !wr_en_o;

  // Index and write strobe
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      idx_q   <= '0;
      wr_en_o <= 1'b0;
    end else begin
      wr_en_o <= push;
      if (push) begin
        if (idx_q == LAST_IDX) begin
          idx_q <= '0;
        end else begin
          idx_q <= idx_q + 1'b1;
        end
      end
    end
  end

  // Byte that goes with the strobe
  always_ff @(posedge clk_i) begin
    if (push) begin
      wr_data_o <= MSG_TABLE[idx_q];
    end
  end

endmodule

`default_nettype wire

// File: rtl/byte_fifo.sv
// First-word-fall-through byte FIFO; DEPTH must be a power of two and writers must respect full_o
`timescale 1ns/1ps
`default_nettype none

`include "uart_hello_defines.svh"

module byte_fifo #(
  parameter int DEPTH = `FIFO_DEPTH
) (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  wr_en_i,
  input  uart_hello_pkg::byte_t wr_data_i,
  input  logic                  rd_en_i,
  output uart_hello_pkg::byte_t rd_data_o,
  output logic                  empty_o,
  output logic                  full_o
);

  import uart_hello_pkg::*;

  localparam int AW = $clog2(DEPTH);

  // Storage, contents are don't-care after reset
  byte_t mem [0:DEPTH-1];

  // Extra MSB tells a full buffer from an empty one
  logic [AW:0] wr_ptr_q;
  logic [AW:0] rd_ptr_q;

  logic [AW-1:0] wr_addr;
  logic [AW-1:0] rd_addr;

  assign wr_addr = wr_ptr_q[AW-1:0];
  assign rd_addr = rd_ptr_q[AW-1:0];

  // Pointers
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (wr_en_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (rd_en_i) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

  // Write port
  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      mem[wr_addr] <= wr_data_i;
    end
  end

  // Head entry is always on the output
  assign rd_data_o = mem[rd_addr];

  assign empty_o = (wr_ptr_q == rd_ptr_q);
  assign full_o  = (wr_ptr_q[AW] != rd_ptr_q[AW]) && (wr_addr == rd_addr);

endmodule

`default_nettype wire

// File: rtl/uart_tx.sv
// 8N1 transmitter at a fixed CLKS_PER_BIT rate; tx_o is registered and trails the FSM by one cycle
`timescale 1ns/1ps
`default_nettype none

`include "uart_hello_defines.svh"

module uart_tx (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  uart_hello_pkg::byte_t rd_data_i,
  input  logic                  empty_i,
  output logic                  rd_en_o,
  output logic                  busy_o,
  output logic                  tx_o
);

  import uart_hello_pkg::*;

  localparam int CNT_W = $clog2(`CLKS_PER_BIT);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`CLKS_PER_BIT - 1);

  tx_state_e        state_q;
  logic [CNT_W-1:0] clk_cnt_q;
  logic [2:0]       bit_cnt_q;
  byte_t            shift_q;
  logic             bit_done;
  logic             line_d;

  // Last cycle of the current bit period
  assign bit_done = (clk_cnt_q == CNT_LAST);

  // Pop only from IDLE; the state change makes it a single pulse
  assign rd_en_o = (state_q == IDLE) && !empty_i;

  assign busy_o = (state_q != IDLE);

  // Line level for the current state
  always_comb begin
    case (state_q)
      START:   line_d = 1'b0;
      DATA:    line_d = shift_q[0];
      default: line_d = 1'b1;
    endcase
  end

  // Bit-period counter, held at zero while idle
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      clk_cnt_q <= '0;
    end else if (state_q == IDLE || bit_done) begin
      clk_cnt_q <= '0;
    end else begin
      clk_cnt_q <= clk_cnt_q + 1'b1;
    end
  end

  // Frame FSM and output register
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q   <= IDLE;
      bit_cnt_q <= '0;
      tx_o      <= 1'b1;
    end else begin
      tx_o <= line_d;
      case (state_q)
        IDLE: begin
          if (rd_en_o) begin
            state_q <= START;
          end
        end
        START: begin
          if (bit_done) begin
            state_q   <= DATA;
            bit_cnt_q <= '0;
          end
        end
        DATA: begin
          if (bit_done) begin
            if (bit_cnt_q == 3'd7) begin
              state_q <= STOP;
            end else begin
              bit_cnt_q <= bit_cnt_q + 1'b1;
            end
          end
        end
        STOP: begin
          if (bit_done) begin
            state_q <= IDLE;
          end
        end
        default: begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  // Byte captured on the pop edge, LSB goes out first
  always_ff @(posedge clk_i) begin
    if (rd_en_o) begin
      shift_q <= rd_data_i;
    end else if (state_q == DATA && bit_done) begin
      shift_q <= {1'b0, shift_q[7:1]};
    end
  end

endmodule

`default_nettype wire

// File: rtl/uart_hello_top.sv
// Board top: repeats the fixed message on uart_tx_o, no receive path and no baud selection
`timescale 1ns/1ps
`default_nettype none

module uart_hello_top (
  input  logic clk_i,
  input  logic arst_n_i,
  input  logic enable_i,
  output logic uart_tx_o,
  output logic led_full_o,
  output logic led_busy_o
);

  import uart_hello_pkg::*;

  // Source to FIFO
  byte_t wr_data;
  logic  wr_en;
  logic  fifo_full;

  // FIFO to transmitter
  byte_t rd_data;
  logic  fifo_empty;
  logic  rd_en;

  logic  tx_busy;

  message_source u_source (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .enable_i  (enable_i),
    .wr_data_o (wr_data),
    .wr_en_o   (wr_en),
    .full_i    (fifo_full)
  );

  byte_fifo u_fifo (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .wr_en_i   (wr_en),
    .wr_data_i (wr_data),
    .rd_en_i   (rd_en),
    .rd_data_o (rd_data),
    .empty_o   (fifo_empty),
    .full_o    (fifo_full)
  );

  uart_tx u_tx (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .rd_data_i (rd_data),
    .empty_i   (fifo_empty),
    .rd_en_o   (rd_en),
    .busy_o    (tx_busy),
    .tx_o      (uart_tx_o)
  );

  // Status LEDs
  assign led_full_o = fifo_full;
  assign led_busy_o = tx_busy;

endmodule

`default_nettype wire

// File: tests/uart_rx_monitor.sv
// Testbench-only 8N1 decoder synchronous to clk_i, which expects a glitch-free line
`timescale 1ns/1ps
`default_nettype none

`include "uart_hello_defines.svh"

module uart_rx_monitor (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  rx_i,
  output uart_hello_pkg::byte_t data_o,
  output logic                  valid_o,
  output logic                  start_lvl_o,
  output logic                  stop_lvl_o,
  output int                    bit_time_o
);

  import uart_hello_pkg::*;

  localparam int HALF = `CLKS_PER_BIT / 2;

  tx_state_e state;
  logic      rx_q;
  byte_t     shift;
  int        cnt;
  int        bit_idx;
  int        last_edge;
  int        worst;

  // Bit period implied by the cycles between two line edges
  function automatic int span_to_period(input int span);
    int bits;
    bits = (span + HALF) / `CLKS_PER_BIT;
    if (bits == 0) begin
      return 0;
    end
    return span / bits;
  endfunction

  // Of two periods, the one further from the nominal bit period
  function automatic int further_off(input int a, input int b);
    int da;
    int db;
    da = (a > `CLKS_PER_BIT) ? a - `CLKS_PER_BIT : `CLKS_PER_BIT - a;
    db = (b > `CLKS_PER_BIT) ? b - `CLKS_PER_BIT : `CLKS_PER_BIT - b;
    return (db > da) ? b : a;
  endfunction

  always @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state     <= IDLE;
      rx_q      <= 1'b1;
      valid_o   <= 1'b0;
      cnt       <= 0;
      bit_idx   <= 0;
      last_edge <= 0;
      worst     <= `CLKS_PER_BIT;
    end else begin
      rx_q    <= rx_i;
      valid_o <= 1'b0;
      // Cycles since the falling edge of the start bit
      if (state != IDLE) begin
        cnt <= cnt + 1;
        if (rx_i != rx_q) begin
          last_edge <= cnt;
          worst     <= further_off(worst, span_to_period(cnt - last_edge));
        end
      end
      case (state)
        IDLE: begin
          if (rx_q && !rx_i) begin
            state     <= START;
            cnt       <= 1;
            last_edge <= 0;
            worst     <= `CLKS_PER_BIT;
          end
        end
        START: begin
          if (cnt == HALF) begin
            start_lvl_o <= rx_i;
            bit_idx     <= 0;
            state       <= DATA;
          end
        end
        DATA: begin
          if (cnt == HALF + (bit_idx + 1) * `CLKS_PER_BIT) begin
            shift <= {rx_i, shift[7:1]};
            if (bit_idx == 7) begin
              state <= STOP;
            end else begin
              bit_idx <= bit_idx + 1;
            end
          end
        end
        STOP: begin
          if (cnt == HALF + 9 * `CLKS_PER_BIT) begin
            stop_lvl_o <= rx_i;
            data_o     <= shift;
            bit_time_o <= worst;
            valid_o    <= 1'b1;
            state      <= IDLE;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: tests/uart_hello_tb.sv
// Run from the project root so the pattern file resolves; a full run takes about 56k clocks
`timescale 1ns/1ps
`default_nettype none

`include "uart_hello_defines.svh"

module uart_hello_tb;

  import uart_hello_pkg::*;

  localparam int  PAT_WORDS    = `MSG_LEN + 2;
  localparam int  RESET_CYCLES = 8;
  localparam int  RESUME_BYTES = 3;
  localparam real CLK_PERIOD   = 100.0;

  logic clk = 1'b0;
  logic arst_n;
  logic enable;
  logic tx_line;
  logic led_full;
  logic led_busy;

  byte_t mon_data;
  logic  mon_valid;
  logic  mon_start;
  logic  mon_stop;
  int    mon_bit_time;

  logic [31:0] pat [0:PAT_WORDS-1];
  byte_t       msg [0:`MSG_LEN-1];
  int          num_passes;
  int          window_cycles;
  logic        pat_loaded = 1'b0;

  int       check_cnt   = 0;
  int       err_cnt     = 0;
  int       byte_cnt    = 0;
  int       frame_cnt   = 0;
  int       frame_errs  = 0;
  int       timing_errs = 0;
  msg_idx_t exp_idx     = '0;
  logic     track_full  = 1'b0;
  logic     seen_full   = 1'b0;

  uart_hello_top UUT (
    .clk_i      (clk),
    .arst_n_i   (arst_n),
    .enable_i   (enable),
    .uart_tx_o  (tx_line),
    .led_full_o (led_full),
    .led_busy_o (led_busy)
  );

  uart_rx_monitor u_monitor (
    .clk_i       (clk),
    .arst_n_i    (arst_n),
    .rx_i        (tx_line),
    .data_o      (mon_data),
    .valid_o     (mon_valid),
    .start_lvl_o (mon_start),
    .stop_lvl_o  (mon_stop),
    .bit_time_o  (mon_bit_time)
  );

  always #(CLK_PERIOD / 2.0) clk = ~clk;

  // Latch any full LED seen while streaming
  always @(posedge clk) begin
    if (track_full && led_full) begin
      seen_full <= 1'b1;
    end
  end

  task automatic check_byte(input byte_t exp, input byte_t got, input string what);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("Fail at %0t: %s expected 0x%02h, got 0x%02h", $time, what, exp, got);
    end
  endtask

  task automatic check_bit_time(input int exp, input int got, input string what);
    check_cnt++;
    if (got < exp - 1 || got > exp + 1) begin
      err_cnt++;
      $display("Fail at %0t: %s expected %0d clocks, got %0d", $time, what, exp, got);
    end
  endtask

  task automatic check_level(input logic exp, input logic got, input string what);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("Fail at %0t: %s expected %b, got %b", $time, what, exp, got);
    end
  endtask

  task automatic check_count(input int limit, input int got, input string what);
    check_cnt++;
    if (got > limit) begin
      err_cnt++;
      $display("Fail at %0t: %s expected at most %0d, got %0d", $time, what, limit, got);
    end
  endtask

  task automatic report_test(input int num, input string name, input int errs);
    if (errs == 0) begin
      $display("Test %0d %s: passed", num, name);
    end else begin
      $display("Test %0d %s: failed with %0d errors", num, name, errs);
    end
  endtask

  task automatic load_patterns(output logic ok);
    $readmemh("tests/uart_hello_patterns.mem", pat);
    ok = !$isunknown(pat[PAT_WORDS-1]);
    if (ok) begin
      for (int i = 0; i < `MSG_LEN; i++) begin
        msg[i] = pat[i][7:0];
      end
      num_passes    = pat[`MSG_LEN];
      window_cycles = pat[`MSG_LEN+1];
    end
  endtask

  // Frame format and bit period of the frame the monitor just finished
  task automatic handle_frame(output byte_t data);
    int e0;
    e0 = err_cnt;
    check_level(1'b0, mon_start, "start bit level");
    check_level(1'b1, mon_stop, "stop bit level");
    frame_errs += err_cnt - e0;
    e0 = err_cnt;
    check_bit_time(`CLKS_PER_BIT, mon_bit_time, "bit period");
    timing_errs += err_cnt - e0;
    frame_cnt++;
    data = mon_data;
  endtask

  task automatic wait_frame(output byte_t data);
    do begin
      @(posedge clk);
    end while (!mon_valid);
    handle_frame(data);
  endtask

  // Compare with the next message byte and step through the table
  task automatic expect_next_byte(input byte_t got, input string what);
    check_byte(msg[exp_idx], got, $sformatf("%s %0d", what, exp_idx));
    byte_cnt++;
    if (exp_idx == msg_idx_t'(`MSG_LEN - 1)) begin
      exp_idx = '0;
    end else begin
      exp_idx = exp_idx + 1'b1;
    end
  endtask

  task automatic verify_reset_state();
    int e0;
    e0 = err_cnt;
    repeat (RESET_CYCLES / 2) @(posedge clk);
    check_level(1'b1, tx_line, "line during reset");
    check_level(1'b0, led_full, "full LED during reset");
    check_level(1'b0, led_busy, "busy LED during reset");
    repeat (RESET_CYCLES - RESET_CYCLES / 2) @(posedge clk);
    arst_n <= 1'b1;
    repeat (2) @(posedge clk);
    check_level(1'b1, tx_line, "line after reset");
    check_level(1'b0, led_full, "full LED after reset");
    check_level(1'b0, led_busy, "busy LED after reset");
    report_test(1, "reset state", err_cnt - e0);
  endtask

  task automatic stream_message();
    byte_t got;
    int    e0;
    e0 = err_cnt;
    track_full = 1'b1;
    enable <= 1'b1;
    for (int i = 0; i < num_passes * `MSG_LEN; i++) begin
      wait_frame(got);
      // Monitor reports at mid stop bit, so the frame is still on the line
      check_level(1'b1, led_busy, "busy LED during frame");
      expect_next_byte(got, "message byte");
    end
    track_full = 1'b0;
    check_level(1'b1, seen_full, "full LED under back-pressure");
    report_test(4, "message content and wrap", err_cnt - e0);
  endtask

  task automatic pause_and_resume();
    msg_idx_t drop_pos;
    byte_t    got;
    int       extra;
    int       e0;
    e0 = err_cnt;
    extra = 0;
    drop_pos = msg_idx_t'($urandom % `MSG_LEN);
    while (exp_idx != drop_pos) begin
      wait_frame(got);
      expect_next_byte(got, "byte before pause");
    end
    enable <= 1'b0;
    // Whatever is buffered drains during the window
    repeat (window_cycles) begin
      @(posedge clk);
      if (mon_valid) begin
        handle_frame(got);
        expect_next_byte(got, "byte drained in pause");
        extra++;
      end
    end
    check_count(`FIFO_DEPTH, extra, "bytes sent after enable dropped");
    check_level(1'b1, tx_line, "line at end of pause");
    check_level(1'b0, led_busy, "busy LED at end of pause");
    enable <= 1'b1;
    repeat (RESUME_BYTES) begin
      wait_frame(got);
      expect_next_byte(got, "byte after resume");
    end
    report_test(5, $sformatf("pause at byte %0d and resume, %0d bytes drained", drop_pos, extra),
                err_cnt - e0);
  endtask

  initial begin : main
    logic ok;
    $timeformat(-9, 0, " ns", 0);
    arst_n = 1'b0;
    enable = 1'b0;
    void'($urandom(32'h123b));
    load_patterns(ok);
    if (ok) begin
      pat_loaded = 1'b1;
      verify_reset_state();
      stream_message();
      pause_and_resume();
      report_test(2, $sformatf("frame format over %0d frames", frame_cnt), frame_errs);
      report_test(3, $sformatf("bit timing over %0d frames", frame_cnt), timing_errs);
    end else begin
      err_cnt++;
      $display("Error: the pattern file tests/uart_hello_patterns.mem could not be read");
    end
    $display("Checks: %0d, frames: %0d, errors: %0d", check_cnt, frame_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // Streaming passes plus the pause window and half again for margin
  initial begin : watchdog
    real limit_ns;
    wait (pat_loaded);
    limit_ns = 1.5 * CLK_PERIOD
             * (real'(num_passes * `MSG_LEN * 10 * `CLKS_PER_BIT) + real'(window_cycles));
    #(limit_ns);
    $display("Timeout: the UART line stopped sending after %0d bytes", byte_cnt);
    $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+rtl
rtl/uart_hello_pkg.sv
rtl/message_source.sv
rtl/byte_fifo.sv
rtl/uart_tx.sv
rtl/uart_hello_top.sv
tests/uart_rx_monitor.sv
tests/uart_hello_tb.sv

// File: tests/uart_hello_patterns.mem
// Words 0 to 14: expected message bytes in send order
// Word 15: message passes checked with enable high; word 16: enable-low window in clock cycles
48
65
6C
6C
6F
2C
20
46
69
66
6F
21
21
0D
0A
00000002
00003A98
